/* audio_cfg_pkg.sv */
////////////////////////////////////////
// Audio datapath types
////////////////////////////////////////

package audio_cfg_pkg;

  // Word length code, same encoding as the codec WL field
  typedef enum logic [1:0] {
    wl_16 = 2'd0,
    wl_20 = 2'd1,
    wl_24 = 2'd2,
    wl_32 = 2'd3
  } word_len_e;

  // One channel, right-justified
  typedef logic [31:0] sample_t;

  // Left in [31:0], right in [63:32]
  typedef logic [63:0] sample_pair_t;

  // Sample FIFO sizing
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
  // Occupancy 0 to fifo_depth
  typedef logic [fifo_ptr_w:0]   fifo_count_t;

endpackage

/* apb_map_pkg.sv */
////////////////////////////////////////
// APB register map
////////////////////////////////////////

package apb_map_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Register offsets
  localparam apb_addr_t reg_ctrl     = 8'h00;
  localparam apb_addr_t reg_left     = 8'h04;
  localparam apb_addr_t reg_right    = 8'h08;
  localparam apb_addr_t reg_status   = 8'h0C;
  localparam apb_addr_t reg_underrun = 8'h10;

  // Control fields
  localparam int ctrl_en_bit = 0;
  localparam int ctrl_wl_lsb = 1;
  localparam int ctrl_wl_msb = 2;

  // Status fields
  localparam int status_level_lsb = 0;
  localparam int status_level_msb = 3;
  localparam int status_full_bit  = 4;
  localparam int status_empty_bit = 5;

  typedef logic [15:0] underrun_cnt_t;

endpackage

/* apb_audio_regs.sv */
////////////////////////////////////////
// APB audio register block
////////////////////////////////////////
`timescale 1ns/100ps

module apb_audio_regs
  import audio_cfg_pkg::*;
  import apb_map_pkg::*;
(
  input  logic         ac_bclk,
  input  logic         reset,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  apb_addr_t    paddr,
  input  apb_data_t    pwdata,
  input  logic         fifo_full,
  input  logic         fifo_empty,
  input  fifo_count_t  fifo_level,
  input  logic         underrun,
  output apb_data_t    prdata,
  output logic         pready,
  output logic         pslverr,
  output logic         push,
  output sample_pair_t push_data,
  output logic         enable,
  output word_len_e    word_length
);

  // Access phase of an APB transfer
  logic          access;
  logic          write_en;
  logic          right_wr;
  logic          addr_hit;
  sample_t       left_q;
  underrun_cnt_t underrun_cnt;

  assign access   = psel && penable;
  assign write_en = access && pwrite;
  // Right channel write is the push trigger
  assign right_wr = write_en && (paddr == reg_right);

  ////////////////////////////////////////
  // FIFO push and back-pressure
  ////////////////////////////////////////

  // Hold the transfer in access phase while the FIFO is full
  assign pready    = !(right_wr && fifo_full);
  assign push      = right_wr && !fifo_full;
  assign push_data = {sample_t'(pwdata), left_q};

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge ac_bclk) begin
    if (reset) begin
      enable       <= 1'b0;
      word_length  <= wl_16;
      left_q       <= '0;
      underrun_cnt <= '0;
    end else begin
      if (write_en && (paddr == reg_ctrl)) begin
        enable      <= pwdata[ctrl_en_bit];
        word_length <= word_len_e'(pwdata[ctrl_wl_msb:ctrl_wl_lsb]);
      end
      // Left is staged until the right write arrives
      if (write_en && (paddr == reg_left)) begin
        left_q <= pwdata;
      end
      // Clear on any write, else saturating count
      if (write_en && (paddr == reg_underrun)) begin
        underrun_cnt <= '0;
      end else if (underrun && (underrun_cnt != '1)) begin
        underrun_cnt <= underrun_cnt + 16'd1;
      end
    end
  end

  ////////////////////////////////////////
  // Read mux and decode error
  ////////////////////////////////////////

  always_comb begin
    prdata   = '0;
    addr_hit = 1'b1;
    case (paddr)
      reg_ctrl: begin
        prdata[ctrl_en_bit]             = enable;
        prdata[ctrl_wl_msb:ctrl_wl_lsb] = word_length;
      end
      reg_left:     prdata = left_q;
      // Right is write-only, reads as zero
      reg_right:    prdata = '0;
      reg_status: begin
        prdata[status_level_msb:status_level_lsb] = fifo_level;
        prdata[status_full_bit]                   = fifo_full;
        prdata[status_empty_bit]                  = fifo_empty;
      end
      reg_underrun: prdata = apb_data_t'(underrun_cnt);
      default:      addr_hit = 1'b0;
    endcase
  end

  // Unmapped offset still completes, with no effect
  assign pslverr = access && !addr_hit;

endmodule

/* sample_fifo.sv */
////////////////////////////////////////
// Sample pair FIFO
////////////////////////////////////////
`timescale 1ns/100ps

module sample_fifo
  import audio_cfg_pkg::*;
(
  input  logic         ac_bclk,
  input  logic         reset,
  input  logic         push,
  input  sample_pair_t push_data,
  input  logic         pop_ready,
  output logic         pop_valid,
  output sample_pair_t pop_data,
  output logic         full,
  output logic         empty,
  output fifo_count_t  level
);

  // Storage, no reset needed
  sample_pair_t mem [fifo_depth];

  fifo_ptr_t   wr_ptr;
  fifo_ptr_t   rd_ptr;
  fifo_count_t count;
  logic        do_push;
  logic        do_pop;

  // Guard both sides against overflow and underflow
  assign do_push = push && !full;
  assign do_pop  = pop_ready && !empty;

  // Write side
  always_ff @(posedge ac_bclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap on their own at a power-of-two depth
  always_ff @(posedge ac_bclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head shown early for the consumer
  assign pop_data  = mem[rd_ptr];
  assign empty     = (count == '0);
  assign full      = (count == fifo_count_t'(fifo_depth));
  assign pop_valid = !empty;
  assign level     = count;

endmodule

/* audio_data_serializer.sv */
////////////////////////////////////////
// DSP mode playback serializer
////////////////////////////////////////
`timescale 1ns/100ps

module audio_data_serializer
  import audio_cfg_pkg::*;
(
  input  logic         ac_bclk,
  input  logic         reset,
  input  logic         ac_pblrc,
  input  logic         enable,
  input  word_len_e    word_length,
  input  logic         pop_valid,
  input  sample_pair_t pop_data,
  output logic         ac_pbdat,
  output logic         pop_ready,
  output logic         underrun
);

  sample_t      left_s;
  sample_t      right_s;
  sample_pair_t frame_packed;
  sample_pair_t shift_q;
  logic         load_data;

  assign left_s  = pop_data[31:0];
  assign right_s = pop_data[63:32];

  // Left N bits first, then right N bits, zero padded to 64
  always_comb begin
    case (word_length)
      wl_16:   frame_packed = {left_s[15:0], right_s[15:0], 32'd0};
      wl_20:   frame_packed = {left_s[19:0], right_s[19:0], 24'd0};
      wl_24:   frame_packed = {left_s[23:0], right_s[23:0], 16'd0};
      wl_32:   frame_packed = {left_s, right_s};
      default: frame_packed = '0;
    endcase
  end

  // Real data only when enabled and the FIFO has a pair
  assign load_data = ac_pblrc && enable && pop_valid;

  ////////////////////////////////////////
  // Frame load and shift
  ////////////////////////////////////////

  always_ff @(posedge ac_bclk) begin
    if (reset) begin
      shift_q   <= '0;
      pop_ready <= 1'b0;
      underrun  <= 1'b0;
    end else begin
      pop_ready <= 1'b0;
      underrun  <= 1'b0;
      if (ac_pblrc) begin
        if (load_data) begin
          shift_q   <= frame_packed;
          // Consume the head one cycle after the load
          pop_ready <= 1'b1;
        end else begin
          // Silence frame; only an error when enabled
          shift_q  <= '0;
          underrun <= enable;
        end
      end else begin
        // MSB first, zeros fill in behind
        shift_q <= {shift_q[62:0], 1'b0};
      end
    end
  end

  assign ac_pbdat = shift_q[63];

endmodule

/* audio_playback_top.sv */
////////////////////////////////////////
// Audio playback top level
////////////////////////////////////////
`timescale 1ns/100ps

module audio_playback_top
  import audio_cfg_pkg::*;
  import apb_map_pkg::*;
(
  // Codec side
  input  logic      ac_bclk,
  input  logic      reset,
  input  logic      ac_pblrc,
  output logic      ac_pbdat,
  // APB slave
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  // Register block to FIFO
  logic         push;
  sample_pair_t push_data;
  logic         fifo_full;
  logic         fifo_empty;
  fifo_count_t  fifo_level;

  // FIFO to serializer
  logic         pop_valid;
  logic         pop_ready;
  sample_pair_t pop_data;

  // Serializer config and status
  logic         enable;
  word_len_e    word_length;
  logic         underrun;

  apb_audio_regs u_regs (
    .ac_bclk     (ac_bclk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .fifo_full   (fifo_full),
    .fifo_empty  (fifo_empty),
    .fifo_level  (fifo_level),
    .underrun    (underrun),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .push        (push),
    .push_data   (push_data),
    .enable      (enable),
    .word_length (word_length)
  );

  sample_fifo u_fifo (
    .ac_bclk   (ac_bclk),
    .reset     (reset),
    .push      (push),
    .push_data (push_data),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .full      (fifo_full),
    .empty     (fifo_empty),
    .level     (fifo_level)
  );

  audio_data_serializer u_ser (
    .ac_bclk     (ac_bclk),
    .reset       (reset),
    .ac_pblrc    (ac_pblrc),
    .enable      (enable),
    .word_length (word_length),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .ac_pbdat    (ac_pbdat),
    .pop_ready   (pop_ready),
    .underrun    (underrun)
  );

endmodule

/* tb_clock_gen.sv */
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////
`timescale 1ns/100ps

module tb_clock_gen (
  output logic ac_bclk,
  output logic reset
);

  // Codec bit clock, 4 ns period
  initial begin
    ac_bclk = 1'b0;
    forever #2 ac_bclk = ~ac_bclk;
  end

  // Reset held for two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge ac_bclk);
    reset <= 1'b0;
  end

endmodule

/* tb_audio_playback.sv */
////////////////////////////////////////
// Audio playback testbench
////////////////////////////////////////
`timescale 1ns/100ps

module tb_audio_playback
  import audio_cfg_pkg::*;
  import apb_map_pkg::*;
();

  logic      ac_bclk;
  logic      reset;
  logic      ac_pblrc;
  logic      ac_pbdat;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  // Next frame pulse already raised by the codec model
  logic pulse_pending;
  int   frame_errs;
  int   reg_errs;
  int   level_errs;
  int   other_errs;

  // About 24 frames of 64 cycles plus APB traffic
  localparam int frame_budget    = 25;
  localparam int apb_budget      = 600;
  localparam int watchdog_cycles = frame_budget * 66 + apb_budget;

  tb_clock_gen u_clock_gen (
    .ac_bclk (ac_bclk),
    .reset   (reset)
  );

  audio_playback_top u_audio_playback_top (
    .ac_bclk  (ac_bclk),
    .reset    (reset),
    .ac_pblrc (ac_pblrc),
    .ac_pbdat (ac_pbdat),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge ac_bclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge ac_bclk);
    penable <= 1'b1;
    // Wait states while pready is low
    @(negedge ac_bclk);
    while (!pready) begin
      @(negedge ac_bclk);
    end
    @(posedge ac_bclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(posedge ac_bclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge ac_bclk);
    penable <= 1'b1;
    @(negedge ac_bclk);
    while (!pready) begin
      @(negedge ac_bclk);
    end
    // Read data valid in the completing cycle
    data = prdata;
    err  = pslverr;
    @(posedge ac_bclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic set_ctrl(input logic en, input word_len_e wl);
    apb_write(reg_ctrl, {29'd0, wl, en});
  endtask

  task automatic push_pair(input sample_t left, input sample_t right);
    apb_write(reg_left, left);
    apb_write(reg_right, right);
  endtask

  ////////////////////////////////////////
  // Codec model and expected frames
  ////////////////////////////////////////

  // One-cycle pulse, then 64 bits MSB first
  task automatic codec_frame(input logic more, output sample_pair_t frame);
    int i;
    if (!pulse_pending) begin
      @(posedge ac_bclk);
      ac_pblrc <= 1'b1;
    end
    // Load edge
    @(posedge ac_bclk);
    ac_pblrc <= 1'b0;
    for (i = 63; i > 0; i--) begin
      @(negedge ac_bclk);
      frame[i] = ac_pbdat;
    end
    // Next pulse overlaps bit 0 so frames are 64 cycles apart
    @(posedge ac_bclk);
    if (more) begin
      ac_pblrc <= 1'b1;
    end
    pulse_pending = more;
    @(negedge ac_bclk);
    frame[0] = ac_pbdat;
  endtask

  // Left N low bits from bit 63 down, right N bits after, zeros below
  task automatic expect_frame(input word_len_e wl, input sample_t left, input sample_t right,
                              output sample_pair_t exp);
    int n;
    int i;
    case (wl)
      wl_16:   n = 16;
      wl_20:   n = 20;
      wl_24:   n = 24;
      default: n = 32;
    endcase
    exp = '0;
    for (i = 0; i < n; i++) begin
      exp[63 - i]     = left[n - 1 - i];
      exp[63 - n - i] = right[n - 1 - i];
    end
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_frame(input sample_pair_t got, input sample_pair_t exp, input string what);
    if (got !== exp) begin
      frame_errs++;
      $display("MISMATCH @%0t: %s frame got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp) begin
      reg_errs++;
      $display("MISMATCH @%0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input fifo_count_t got, input fifo_count_t exp, input string what);
    if (got !== exp) begin
      level_errs++;
      $display("MISMATCH @%0t: %s level got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_regs();
    apb_data_t d;
    logic      err;
    apb_read(reg_ctrl, d, err);
    check_reg(d, 32'h0, "reg_ctrl after reset");
    apb_read(reg_underrun, d, err);
    check_reg(d, 32'h0, "reg_underrun after reset");
    apb_read(reg_status, d, err);
    check_reg(d, apb_data_t'(1) << status_empty_bit, "reg_status after reset");
    // Enable with 24-bit words, then back to idle
    set_ctrl(1'b1, wl_24);
    apb_read(reg_ctrl, d, err);
    check_reg(d, 32'h5, "reg_ctrl readback");
    if (err !== 1'b0) begin
      other_errs++;
      $display("Mapped offset reg_ctrl returned pslverr");
    end
    set_ctrl(1'b0, wl_16);
    apb_read(8'h14, d, err);
    if (err !== 1'b1) begin
      other_errs++;
      $display("Unmapped offset 0x14 did not return pslverr");
    end
  endtask

  task automatic test_word_len(input word_len_e wl, input sample_t left, input sample_t right);
    sample_pair_t got;
    sample_pair_t exp;
    set_ctrl(1'b1, wl);
    push_pair(left, right);
    codec_frame(1'b0, got);
    expect_frame(wl, left, right, exp);
    check_frame(got, exp, wl.name());
  endtask

  task automatic test_ordering();
    sample_t      lefts [5];
    sample_t      rights [5];
    sample_pair_t got;
    sample_pair_t exp;
    apb_data_t    d;
    logic         err;
    int           k;
    set_ctrl(1'b1, wl_24);
    for (k = 0; k < 5; k++) begin
      lefts[k]  = $urandom;
      rights[k] = $urandom;
      push_pair(lefts[k], rights[k]);
    end
    apb_read(reg_status, d, err);
    check_level(fifo_count_t'(d[status_level_msb:status_level_lsb]), 4'd5, "queued");
    // Level counts down as each pair is played
    for (k = 0; k < 5; k++) begin
      codec_frame(1'b0, got);
      expect_frame(wl_24, lefts[k], rights[k], exp);
      check_frame(got, exp, "ordering");
      apb_read(reg_status, d, err);
      check_level(fifo_count_t'(d[status_level_msb:status_level_lsb]),
                  fifo_count_t'(4 - k), "draining");
    end
  endtask

  task automatic test_underrun();
    sample_pair_t got;
    sample_pair_t exp;
    apb_data_t    d;
    logic         err;
    int           k;
    set_ctrl(1'b1, wl_16);
    apb_write(reg_underrun, 32'h0);
    // Empty FIFO while enabled, one count per frame
    for (k = 1; k <= 3; k++) begin
      codec_frame(1'b0, got);
      check_frame(got, '0, "underrun");
      apb_read(reg_underrun, d, err);
      check_reg(d, apb_data_t'(k), "reg_underrun count");
    end
    apb_write(reg_underrun, 32'h1234);
    apb_read(reg_underrun, d, err);
    check_reg(d, 32'h0, "reg_underrun after clear");
    // Disabled frames are silent, do not pop and are not counted
    set_ctrl(1'b0, wl_16);
    push_pair(32'h0000_1357, 32'h0000_2468);
    codec_frame(1'b1, got);
    check_frame(got, '0, "disabled");
    codec_frame(1'b0, got);
    check_frame(got, '0, "disabled");
    apb_read(reg_underrun, d, err);
    check_reg(d, 32'h0, "reg_underrun while disabled");
    apb_read(reg_status, d, err);
    check_level(fifo_count_t'(d[status_level_msb:status_level_lsb]), 4'd1,
                "held while disabled");
    // Held pair plays once enabled again
    set_ctrl(1'b1, wl_16);
    codec_frame(1'b0, got);
    expect_frame(wl_16, 32'h0000_1357, 32'h0000_2468, exp);
    check_frame(got, exp, "after disable");
  endtask

  task automatic test_backpressure();
    sample_t      lefts [9];
    sample_t      rights [9];
    sample_pair_t frames [9];
    sample_pair_t exp;
    apb_data_t    d;
    logic         err;
    int           k;
    set_ctrl(1'b1, wl_32);
    for (k = 0; k < 9; k++) begin
      lefts[k]  = $urandom;
      rights[k] = $urandom;
    end
    for (k = 0; k < 8; k++) begin
      push_pair(lefts[k], rights[k]);
    end
    apb_read(reg_status, d, err);
    check_reg(d, (apb_data_t'(8) << status_level_lsb) | (apb_data_t'(1) << status_full_bit),
              "reg_status when full");
    apb_write(reg_left, lefts[8]);
    // Ninth push stalls until the first frame frees a slot
    fork
      apb_write(reg_right, rights[8]);
      begin
        repeat (4) @(negedge ac_bclk);
        if (pready !== 1'b0) begin
          other_errs++;
          $display("pready was not held low while the FIFO was full");
        end
        codec_frame(1'b1, frames[0]);
      end
    join
    for (k = 1; k < 9; k++) begin
      codec_frame(k != 8, frames[k]);
    end
    for (k = 0; k < 9; k++) begin
      expect_frame(wl_32, lefts[k], rights[k], exp);
      check_frame(frames[k], exp, "back-pressure");
    end
    apb_read(reg_status, d, err);
    check_reg(d, apb_data_t'(1) << status_empty_bit, "reg_status after drain");
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    void'($urandom(58182));
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    ac_pblrc      = 1'b0;
    pulse_pending = 1'b0;
    frame_errs    = 0;
    reg_errs      = 0;
    level_errs    = 0;
    other_errs    = 0;
    @(posedge ac_bclk);
    while (reset) begin
      @(posedge ac_bclk);
    end
    test_reset_regs();
    test_word_len(wl_16, 32'h0000_A5C3, 32'h0000_3C5A);
    test_word_len(wl_24, 32'h00F0_1E2D, 32'h0081_7E42);
    test_word_len(wl_20, $urandom, $urandom);
    test_word_len(wl_32, $urandom, $urandom);
    test_ordering();
    test_underrun();
    test_backpressure();
    $display("Errors: frame %0d, register %0d, level %0d, other %0d",
             frame_errs, reg_errs, level_errs, other_errs);
    if (frame_errs + reg_errs + level_errs + other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge ac_bclk);
    $display("Run timed out after %0d clock cycles", watchdog_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* all.f */
audio_cfg_pkg.sv
apb_map_pkg.sv
apb_audio_regs.sv
sample_fifo.sv
audio_data_serializer.sv
audio_playback_top.sv
tb_clock_gen.sv
tb_audio_playback.sv

/* Makefile */
# Verilator flow for the audio playback testbench

TOP = tb_audio_playback

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

# Pass only when the log holds the pass message
sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
